// ==== design/demosaic_defs.svh ====
// size macros for the acpi red/blue demosaic stage.
// include wherever a channel width, line length or pipeline depth is needed.

`ifndef DEMOSAIC_DEFS_SVH
`define DEMOSAIC_DEFS_SVH

// bits per colour channel.
`define DEMOSAIC_CH_BITS 10

// depth of each line memory in the window buffer.
`define DEMOSAIC_MAX_COLS 1024

// register stages in acpi_rb_calc.
`define DEMOSAIC_CALC_LATENCY 4

`endif

// ==== design/demosaic_pkg.sv ====
// types shared by the demosaic rtl and its testbench.
// referenced by scoped name, compiled ahead of every module.

`include "demosaic_defs.svh"

package demosaic_pkg;

    typedef logic [`DEMOSAIC_CH_BITS-1:0] ch_t;  // one colour channel.

    // raw bayer sample with the green from the earlier stage.
    typedef struct packed {
        ch_t raw;
        ch_t g;
    } raw_g_t;

    // red position in the 2x2 bayer cell.
    // bit 1 picks the red row and bit 0 the red column.
    typedef logic [1:0] phase_t;

    typedef logic [$clog2(`DEMOSAIC_MAX_COLS + 1)-1:0] cols_t;  // line length.

endpackage

// ==== design/mat_window_3x3.sv ====
// three-line buffer that turns a raster stream into 3x3 windows.
// borders are reflected reflect-101 style; the bottom row is generated
// from stored lines during the flush that follows the last pixel.

`timescale 1ns/1ps
`default_nettype none

`include "demosaic_defs.svh"

module mat_window_3x3 #(
    parameter type data_t = demosaic_pkg::raw_g_t
) (
    input  var logic                clk,
    input  var logic                rst,
    input  var logic                cke,
    input  var demosaic_pkg::cols_t cols,
    input  var logic                s_row_first,
    input  var logic                s_row_last,
    input  var logic                s_col_first,
    input  var logic                s_col_last,
    input  var logic                s_de,
    input  var logic                s_valid,
    input  var data_t               s_data,
    output logic                    m_row_first,
    output logic                    m_row_last,
    output logic                    m_col_first,
    output logic                    m_col_last,
    output logic                    m_de,
    output logic                    m_valid,
    output data_t [2:0][2:0]        m_data
);

    localparam int ADDR_BITS = $clog2(`DEMOSAIC_MAX_COLS);
    typedef logic [ADDR_BITS-1:0] addr_t;

    data_t mem0   [`DEMOSAIC_MAX_COLS];  // previous line.
    data_t mem1   [`DEMOSAIC_MAX_COLS];  // line before that.
    logic  de_mem [`DEMOSAIC_MAX_COLS];

    logic                flush;
    demosaic_pkg::cols_t flush_col;
    demosaic_pkg::cols_t in_col;
    logic [1:0]          line_q;         // 0, 1, or 2 and later.
    logic                pend;           // last column window due this cycle.
    logic                pend_row_first;
    logic                pend_row_last;

    logic                push;
    logic                push_last;
    logic                centre_ok;
    logic                centre_first;
    logic                centre_last;
    demosaic_pkg::cols_t push_col;
    logic [1:0]          push_line;
    addr_t               addr;
    data_t               rd0;
    data_t               rd1;
    logic                rd_de;
    logic                emit;
    data_t [2:0]         vec;            // new column with index 0 on top.
    data_t [2:0]         p1;
    data_t [2:0]         p2;
    logic                p1_de;

    always_comb begin
        if (s_col_first) begin
            push_line = s_row_first ? 2'd0 : ((line_q == 2'd0) ? 2'd1 : 2'd2);
        end else begin
            push_line = line_q;
        end
        if (flush) begin
            push         = 1'b1;
            push_col     = flush_col;
            push_last    = (flush_col == cols - 1'b1);
            centre_ok    = 1'b1;
            centre_first = 1'b0;
            centre_last  = 1'b1;          // generated bottom row.
        end else begin
            push         = s_valid;
            push_col     = s_col_first ? '0 : in_col;
            push_last    = s_col_last;
            centre_ok    = (push_line != 2'd0);
            centre_first = (push_line == 2'd1);
            centre_last  = 1'b0;
        end
        addr   = addr_t'(push_col);
        rd0    = mem0[addr];
        rd1    = mem1[addr];
        rd_de  = de_mem[addr];
        vec[0] = centre_first ? s_data : rd1;  // row above reflects to row below.
        vec[1] = rd0;
        vec[2] = flush ? rd1 : s_data;         // row below reflects to row above.
        emit   = push & centre_ok & (push_col != '0);
    end

    always_ff @(posedge clk) begin
        if (cke && push && !flush) begin
            mem0[addr]   <= s_data;
            mem1[addr]   <= rd0;
            de_mem[addr] <= s_de;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flush          <= 1'b0;
            flush_col      <= '0;
            in_col         <= '0;
            line_q         <= 2'd0;
            pend           <= 1'b0;
            pend_row_first <= 1'b0;
            pend_row_last  <= 1'b0;
            m_valid        <= 1'b0;
            m_row_first    <= 1'b0;
            m_row_last     <= 1'b0;
            m_col_first    <= 1'b0;
            m_col_last     <= 1'b0;
            m_de           <= 1'b0;
        end else if (cke) begin
            if (flush) begin
                flush_col <= flush_col + 1'b1;
                if (push_last) begin
                    flush <= 1'b0;
                end
            end else if (s_valid) begin
                in_col <= push_col + 1'b1;
                line_q <= push_line;
                if (s_row_last && s_col_last) begin
                    flush     <= 1'b1;
                    flush_col <= '0;
                end
            end
            pend <= push & centre_ok & push_last;
            if (push && push_last) begin
                pend_row_first <= centre_first;
                pend_row_last  <= centre_last;
            end
            m_valid     <= emit | pend;
            m_row_first <= emit ? centre_first : (pend & pend_row_first);
            m_row_last  <= emit ? centre_last : (pend & pend_row_last);
            m_col_first <= emit & (push_col == 1);
            m_col_last  <= pend;
            m_de        <= (emit | pend) & p1_de;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            if (push) begin
                p2    <= p1;
                p1    <= vec;
                p1_de <= rd_de;
            end
            if (emit || pend) begin
                for (int y = 0; y < 3; y++) begin
                    m_data[y][0] <= (emit && push_col == 1) ? vec[y] : p2[y];
                    m_data[y][1] <= p1[y];
                    m_data[y][2] <= emit ? vec[y] : p2[y];  // right edge mirrors left.
                end
            end
        end
    end

    // the flush owns the line memories until the bottom row is out.
    assert property (@(posedge clk) disable iff (rst) (flush && cke) |-> !s_valid);

    // frame and line starts only count on a transferred pixel.
    assert property (@(posedge clk) disable iff (rst)
        (s_row_first || s_col_first) |-> s_valid);

endmodule

`default_nettype wire

// ==== design/acpi_rb_calc.sv ====
// red and blue estimation from colour differences against green.
// four register stages from window to output, all held while cke is low.

`timescale 1ns/1ps
`default_nettype none

`include "demosaic_defs.svh"

module acpi_rb_calc (
    input  var logic                            clk,
    input  var logic                            rst,
    input  var logic                            cke,
    input  var demosaic_pkg::phase_t            param_phase,
    input  var logic                            in_line_first,
    input  var logic                            in_pixel_first,
    input  var demosaic_pkg::raw_g_t [2:0][2:0] in_data,
    output demosaic_pkg::ch_t                   out_raw,
    output demosaic_pkg::ch_t                   out_r,
    output demosaic_pkg::ch_t                   out_g,
    output demosaic_pkg::ch_t                   out_b
);

    localparam int CW = $bits(demosaic_pkg::ch_t);
    localparam int EW = CW + 3;                   // room for four-way sums.
    typedef logic signed [EW-1:0] est_t;
    localparam est_t CH_MAX = est_t'((1 << CW) - 1);

    function automatic est_t ext(input demosaic_pkg::ch_t c);
        return est_t'({3'b000, c});
    endfunction

    function automatic demosaic_pkg::ch_t clamp(input est_t v);
        if (v < 0) begin
            return '0;
        end
        if (v > CH_MAX) begin
            return '1;
        end
        return v[CW-1:0];
    endfunction

    logic x_q;
    logic y_q;
    logic x_cur;
    logic y_cur;
    logic [`DEMOSAIC_CALC_LATENCY-1:0] known_q;
    est_t dh;
    est_t dv;
    est_t dd;

    est_t              s1_dh, s1_dv, s1_dd;
    demosaic_pkg::ch_t s1_raw, s1_g;
    logic              s1_red, s1_blue, s1_red_row;
    est_t              s2_eh, s2_ev, s2_ed;
    demosaic_pkg::ch_t s2_raw, s2_g;
    logic              s2_red, s2_blue, s2_red_row;
    est_t              s3_r, s3_b;
    demosaic_pkg::ch_t s3_raw, s3_g;

    always_comb begin
        x_cur = in_pixel_first ? 1'b0 : ~x_q;
        if (in_pixel_first) begin
            y_cur = in_line_first ? 1'b0 : ~y_q;
        end else begin
            y_cur = y_q;
        end
        dh = ext(in_data[1][0].raw) + ext(in_data[1][2].raw)
           - ext(in_data[1][0].g) - ext(in_data[1][2].g);
        dv = ext(in_data[0][1].raw) + ext(in_data[2][1].raw)
           - ext(in_data[0][1].g) - ext(in_data[2][1].g);
        dd = ext(in_data[0][0].raw) + ext(in_data[0][2].raw)
           + ext(in_data[2][0].raw) + ext(in_data[2][2].raw)
           - ext(in_data[0][0].g) - ext(in_data[0][2].g)
           - ext(in_data[2][0].g) - ext(in_data[2][2].g);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_q     <= 1'b0;
            y_q     <= 1'b0;
            known_q <= '0;
        end else if (cke) begin
            x_q     <= x_cur;
            y_q     <= y_cur;
            known_q <= {known_q[`DEMOSAIC_CALC_LATENCY-2:0], known_q[0] | in_pixel_first};
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            s1_dh      <= dh;
            s1_dv      <= dv;
            s1_dd      <= dd;
            s1_raw     <= in_data[1][1].raw;
            s1_g       <= in_data[1][1].g;
            s1_red_row <= (y_cur == param_phase[1]);
            s1_red     <= (y_cur == param_phase[1]) && (x_cur == param_phase[0]);
            s1_blue    <= (y_cur != param_phase[1]) && (x_cur != param_phase[0]);

            s2_eh      <= ext(s1_g) + (s1_dh >>> 1);  // floor halves.
            s2_ev      <= ext(s1_g) + (s1_dv >>> 1);
            s2_ed      <= ext(s1_g) + (s1_dd >>> 2);
            s2_raw     <= s1_raw;
            s2_g       <= s1_g;
            s2_red     <= s1_red;
            s2_blue    <= s1_blue;
            s2_red_row <= s1_red_row;

            if (s2_red) begin
                s3_r <= ext(s2_raw);
                s3_b <= s2_ed;
            end else if (s2_blue) begin
                s3_r <= s2_ed;
                s3_b <= ext(s2_raw);
            end else if (s2_red_row) begin
                s3_r <= s2_eh;  // green between reds.
                s3_b <= s2_ev;
            end else begin
                s3_r <= s2_ev;
                s3_b <= s2_eh;
            end
            s3_raw <= s2_raw;
            s3_g   <= s2_g;

            out_raw <= s3_raw;
            out_g   <= s3_g;
            out_r   <= clamp(s3_r);
            out_b   <= clamp(s3_b);
        end
    end

    // once a real window has run through every stage the outputs are known.
    assert property (@(posedge clk) disable iff (rst)
        known_q[`DEMOSAIC_CALC_LATENCY-1] |-> !$isunknown({out_raw, out_r, out_g, out_b}));

endmodule

`default_nettype wire

// ==== design/mat_flag_delay.sv ====
// delays the window flags to line up with the calculator output.
// latency is set by the instantiating module.

`timescale 1ns/1ps
`default_nettype none

module mat_flag_delay #(
    parameter int LATENCY = 1
) (
    input  var logic clk,
    input  var logic rst,
    input  var logic cke,
    input  var logic s_row_first,
    input  var logic s_row_last,
    input  var logic s_col_first,
    input  var logic s_col_last,
    input  var logic s_de,
    input  var logic s_valid,
    output logic     m_row_first,
    output logic     m_row_last,
    output logic     m_col_first,
    output logic     m_col_last,
    output logic     m_de,
    output logic     m_valid
);

    logic [LATENCY-1:0][5:0] pipe;  // stage 0 takes the input.

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe <= '0;
        end else if (cke) begin
            pipe[0] <= {s_row_first, s_row_last, s_col_first, s_col_last, s_de, s_valid};
            for (int i = 1; i < LATENCY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign {m_row_first, m_row_last, m_col_first, m_col_last, m_de, m_valid} =
        pipe[LATENCY-1];

endmodule

`default_nettype wire

// ==== design/demosaic_acpi_rb_core.sv ====
// acpi red/blue demosaic stage for a bayer stream with green already filled.
// window buffer feeds the calculator; flags follow through a matching delay.

`timescale 1ns/1ps
`default_nettype none

`include "demosaic_defs.svh"

module demosaic_acpi_rb_core (
    input  var logic                 clk,
    input  var logic                 rst,
    input  var logic                 cke,
    input  var demosaic_pkg::cols_t  cols,
    input  var demosaic_pkg::phase_t param_phase,
    input  var logic                 s_row_first,
    input  var logic                 s_row_last,
    input  var logic                 s_col_first,
    input  var logic                 s_col_last,
    input  var logic                 s_de,
    input  var demosaic_pkg::ch_t    s_raw,
    input  var demosaic_pkg::ch_t    s_g,
    input  var logic                 s_valid,
    output logic                     m_row_first,
    output logic                     m_row_last,
    output logic                     m_col_first,
    output logic                     m_col_last,
    output logic                     m_de,
    output demosaic_pkg::ch_t        m_raw,
    output demosaic_pkg::ch_t        m_r,
    output demosaic_pkg::ch_t        m_g,
    output demosaic_pkg::ch_t        m_b,
    output logic                     m_valid
);

    demosaic_pkg::raw_g_t            s_data;
    demosaic_pkg::raw_g_t [2:0][2:0] win_data;
    logic win_row_first;
    logic win_row_last;
    logic win_col_first;
    logic win_col_last;
    logic win_de;
    logic win_valid;

    assign s_data = '{raw: s_raw, g: s_g};

    mat_window_3x3 #(
        .data_t      (demosaic_pkg::raw_g_t)
    ) u_window (
        .clk         (clk),
        .rst         (rst),
        .cke         (cke),
        .cols        (cols),
        .s_row_first (s_row_first),
        .s_row_last  (s_row_last),
        .s_col_first (s_col_first),
        .s_col_last  (s_col_last),
        .s_de        (s_de),
        .s_valid     (s_valid),
        .s_data      (s_data),
        .m_row_first (win_row_first),
        .m_row_last  (win_row_last),
        .m_col_first (win_col_first),
        .m_col_last  (win_col_last),
        .m_de        (win_de),
        .m_valid     (win_valid),
        .m_data      (win_data)
    );

    acpi_rb_calc u_calc (
        .clk            (clk),
        .rst            (rst),
        .cke            (cke),
        .param_phase    (param_phase),
        .in_line_first  (win_row_first & win_valid),
        .in_pixel_first (win_col_first & win_valid),
        .in_data        (win_data),
        .out_raw        (m_raw),
        .out_r          (m_r),
        .out_g          (m_g),
        .out_b          (m_b)
    );

    mat_flag_delay #(
        .LATENCY     (`DEMOSAIC_CALC_LATENCY)
    ) u_flag_delay (
        .clk         (clk),
        .rst         (rst),
        .cke         (cke),
        .s_row_first (win_row_first),
        .s_row_last  (win_row_last),
        .s_col_first (win_col_first),
        .s_col_last  (win_col_last),
        .s_de        (win_de),
        .s_valid     (win_valid),
        .m_row_first (m_row_first),
        .m_row_last  (m_row_last),
        .m_col_first (m_col_first),
        .m_col_last  (m_col_last),
        .m_de        (m_de),
        .m_valid     (m_valid)
    );

endmodule

`default_nettype wire

// ==== test/demosaic_checker.sv ====
// scoreboard for the demosaic core outputs.
// the testbench queues one expected word per pixel and each output pixel pops one.

`timescale 1ns/1ps

`include "demosaic_defs.svh"

module demosaic_checker (
    input  var logic              clk,
    input  var logic              rst,
    input  var logic              cke,
    input  var logic              m_valid,
    input  var logic              m_row_first,
    input  var logic              m_row_last,
    input  var logic              m_col_first,
    input  var logic              m_col_last,
    input  var logic              m_de,
    input  var demosaic_pkg::ch_t m_raw,
    input  var demosaic_pkg::ch_t m_r,
    input  var demosaic_pkg::ch_t m_g,
    input  var demosaic_pkg::ch_t m_b,
    output int                    err_count,
    output int                    seen_count
);

    localparam int CW = `DEMOSAIC_CH_BITS;
    localparam int EW = 4 * CW + 5;  // flags, raw, red, green, blue.

    logic [EW-1:0] exp_q [$];
    logic [EW-1:0] exp_w;

    function automatic void expect_pixel(input logic [EW-1:0] w);
        exp_q.push_back(w);
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int compare_field(input string name, input logic [CW-1:0] got,
                                         input logic [CW-1:0] want);
        if (got === want) return 0;
        $display("FAIL %s: got 0x%h, expected 0x%h at output pixel %0d",
                 name, got, want, seen_count);
        return 1;
    endfunction

    // outputs hold while cke is low, so each pixel is taken at one enabled edge.
    always @(posedge clk) begin
        if (rst) begin
            err_count  = 0;
            seen_count = 0;
        end else if (cke && m_valid) begin
            if (exp_q.size() == 0) begin
                $display("output pixel %0d arrived with no expected pixel queued", seen_count);
                err_count = err_count + 1;
            end else begin
                exp_w = exp_q.pop_front();
                err_count = err_count
                    + compare_field("m_row_first", CW'(m_row_first), CW'(exp_w[EW-1]))
                    + compare_field("m_row_last", CW'(m_row_last), CW'(exp_w[EW-2]))
                    + compare_field("m_col_first", CW'(m_col_first), CW'(exp_w[EW-3]))
                    + compare_field("m_col_last", CW'(m_col_last), CW'(exp_w[EW-4]))
                    + compare_field("m_de", CW'(m_de), CW'(exp_w[EW-5]))
                    + compare_field("m_raw", m_raw, exp_w[4*CW-1 -: CW])
                    + compare_field("m_r", m_r, exp_w[3*CW-1 -: CW])
                    + compare_field("m_g", m_g, exp_w[2*CW-1 -: CW])
                    + compare_field("m_b", m_b, exp_w[CW-1:0]);
            end
            seen_count = seen_count + 1;
        end
    end

endmodule

// ==== test/tb_demosaic_acpi_rb.sv ====
// testbench for the acpi red/blue demosaic core.
// drives whole bayer frames, queues reference pixels for the checker, reports per test.

`timescale 1ns/1ps

`include "demosaic_defs.svh"

module tb_demosaic_acpi_rb;

    localparam int ROWS   = 8;
    localparam int COLS   = 16;
    localparam int CH_MAX = (1 << `DEMOSAIC_CH_BITS) - 1;
    localparam int EXP_W  = 4 * `DEMOSAIC_CH_BITS + 5;

    logic clk, rst, cke, s_valid, s_de;
    logic s_row_first, s_row_last, s_col_first, s_col_last;
    logic m_row_first, m_row_last, m_col_first, m_col_last, m_de, m_valid;
    demosaic_pkg::cols_t  cols;
    demosaic_pkg::phase_t param_phase;
    demosaic_pkg::ch_t    s_raw, s_g, m_raw, m_r, m_g, m_b;
    int err_count, seen_count;

    int img_raw [ROWS][COLS];
    int img_g   [ROWS][COLS];
    int rnd_raw [ROWS][COLS];  // random frame reused by several tests.
    int rnd_g   [ROWS][COLS];
    logic stall;
    logic aborted;
    int tb_errs, tests_run, tests_failed;

    demosaic_acpi_rb_core uut (.*);

    demosaic_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int reflect(input int i, input int n);
        if (i < 0) return 1;       // edge pixel is not repeated.
        if (i >= n) return n - 2;
        return i;
    endfunction

    function automatic int floor_div(input int a, input int d);
        if (a >= 0) return a / d;
        return -((d - 1 - a) / d);
    endfunction

    function automatic int clamp_ch(input int v);
        if (v < 0) return 0;
        if (v > CH_MAX) return CH_MAX;
        return v;
    endfunction

    // expected word holds row_first, row_last, col_first, col_last, de, raw, red, green, blue.
    function automatic logic [EXP_W-1:0] reference_pixel(input int r, input int c,
                                                         input demosaic_pkg::phase_t ph);
        int u, d, l, rt, g0, eh, ev, ed, red, blue;
        logic red_row, red_col;
        u  = reflect(r - 1, ROWS);
        d  = reflect(r + 1, ROWS);
        l  = reflect(c - 1, COLS);
        rt = reflect(c + 1, COLS);
        g0 = img_g[r][c];
        eh = g0 + floor_div(img_raw[r][l] + img_raw[r][rt] - img_g[r][l] - img_g[r][rt], 2);
        ev = g0 + floor_div(img_raw[u][c] + img_raw[d][c] - img_g[u][c] - img_g[d][c], 2);
        ed = g0 + floor_div(img_raw[u][l] + img_raw[u][rt] + img_raw[d][l] + img_raw[d][rt]
                            - img_g[u][l] - img_g[u][rt] - img_g[d][l] - img_g[d][rt], 4);
        red_row = ((r % 2) == int'(ph[1]));
        red_col = ((c % 2) == int'(ph[0]));
        if (red_row && red_col) begin
            red  = img_raw[r][c];
            blue = ed;
        end else if (!red_row && !red_col) begin
            red  = ed;
            blue = img_raw[r][c];
        end else if (red_row) begin
            red  = eh;  // green between two reds.
            blue = ev;
        end else begin
            red  = ev;
            blue = eh;
        end
        return {r == 0, r == ROWS - 1, c == 0, c == COLS - 1, 1'b1,
                demosaic_pkg::ch_t'(img_raw[r][c]), demosaic_pkg::ch_t'(clamp_ch(red)),
                demosaic_pkg::ch_t'(g0), demosaic_pkg::ch_t'(clamp_ch(blue))};
    endfunction

    task automatic load_frame(input int kind);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                case (kind)
                    0: img_raw[r][c] = (r * 37 + c * 11) % (CH_MAX + 1);
                    1: img_raw[r][c] = rnd_raw[r][c];
                    2: img_raw[r][c] = ((r + c) % 2 == 1) ? CH_MAX : 0;
                    default: img_raw[r][c] = int'($urandom_range(CH_MAX));
                endcase
                case (kind)
                    0: img_g[r][c] = img_raw[r][c];  // grey frame where raw equals green.
                    1: img_g[r][c] = rnd_g[r][c];
                    2: img_g[r][c] = CH_MAX - img_raw[r][c];
                    default: img_g[r][c] = int'($urandom_range(CH_MAX));
                endcase
            end
        end
    endtask

    task automatic tick(output logic took);
        cke = stall ? ($urandom_range(2) != 0) : 1'b1;
        @(posedge clk);
        took = cke;
        #1;
    endtask

    task automatic step_enabled();
        int tries;
        logic took;
        tries = 0;
        took  = 1'b0;
        while (!took && tries < 32) begin
            tick(took);
            tries++;
        end
        if (!took) begin
            $display("clock enable stayed low for %0d cycles", tries);
            tb_errs++;
        end
    endtask

    task automatic drive_frame();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                s_valid     = 1'b1;
                s_de        = 1'b1;
                s_row_first = (r == 0);
                s_row_last  = (r == ROWS - 1);
                s_col_first = (c == 0);
                s_col_last  = (c == COLS - 1);
                s_raw       = demosaic_pkg::ch_t'(img_raw[r][c]);
                s_g         = demosaic_pkg::ch_t'(img_g[r][c]);
                step_enabled();
            end
        end
        s_valid     = 1'b0;
        s_de        = 1'b0;
        s_row_first = 1'b0;
        s_row_last  = 1'b0;
        s_col_first = 1'b0;
        s_col_last  = 1'b0;
        repeat (COLS + 4) step_enabled();  // the window buffer flushes the bottom row here.
    endtask

    task automatic run_test(input string name, input int kind, input int frames,
                            input demosaic_pkg::phase_t ph, input logic drop_cke);
        int errs_before;
        int seen_before;
        int waited;
        logic took;
        if (aborted) return;
        errs_before = err_count + tb_errs;
        seen_before = seen_count;
        param_phase = ph;
        stall       = drop_cke;
        for (int f = 0; f < frames; f++) begin
            load_frame(kind);
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    u_check.expect_pixel(reference_pixel(r, c, ph));
                end
            end
            drive_frame();
        end
        waited = 0;
        while (u_check.pending() != 0 && waited < 400) begin
            tick(took);
            waited++;
        end
        if (u_check.pending() != 0) begin
            $display("%s: timed out with %0d output pixels still missing",
                     name, u_check.pending());
            tb_errs++;
            aborted = 1'b1;
        end else begin
            repeat (8) tick(took);  // any extra pixel would show up here.
            if (seen_count - seen_before != frames * ROWS * COLS) begin
                $display("%s: %0d output pixels seen where %0d were sent",
                         name, seen_count - seen_before, frames * ROWS * COLS);
                tb_errs++;
            end
        end
        tests_run++;
        if (err_count + tb_errs == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    initial begin
        rst         = 1'b1;
        cke         = 1'b1;
        cols        = demosaic_pkg::cols_t'(COLS);
        param_phase = 2'd0;
        s_valid     = 1'b0;
        s_de        = 1'b0;
        s_row_first = 1'b0;
        s_row_last  = 1'b0;
        s_col_first = 1'b0;
        s_col_last  = 1'b0;
        s_raw       = '0;
        s_g         = '0;
        stall       = 1'b0;
        aborted     = 1'b0;
        tb_errs     = 0;
        tests_run   = 0;
        tests_failed = 0;
        void'($urandom(84210));
        load_frame(3);
        rnd_raw = img_raw;
        rnd_g   = img_g;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        run_test("grey frame with raw equal to green", 0, 1, 2'd0, 1'b0);
        run_test("random frame at phase 0", 1, 1, 2'd0, 1'b0);
        for (int ph = 1; ph < 4; ph++) begin
            run_test($sformatf("random frame at phase %0d", ph), 1, 1,
                     demosaic_pkg::phase_t'(ph), 1'b0);
        end
        run_test("checkerboard into both clamp limits", 2, 1, 2'd0, 1'b0);
        run_test("random frame with cke dropped", 1, 1, 2'd0, 1'b1);
        run_test("two back-to-back frames", 3, 2, 2'd0, 1'b0);

        $display("tests run %0d, failed %0d, pixel mismatches %0d, other errors %0d",
                 tests_run, tests_failed, err_count, tb_errs);
        if (tests_failed == 0 && err_count == 0 && tb_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/demosaic_pkg.sv
design/mat_window_3x3.sv
design/acpi_rb_calc.sv
design/mat_flag_delay.sv
design/demosaic_acpi_rb_core.sv
test/demosaic_checker.sv
test/tb_demosaic_acpi_rb.sv

// ==== Makefile ====
# Verilator build and run for the acpi red/blue demosaic testbench.
VERILATOR  ?= verilator
TOP        := tb_demosaic_acpi_rb
RTL_TOP    := demosaic_acpi_rb_core
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
